/* compile.f */
verilog/dnn_mem_pkg.sv
verilog/fifo_if.sv
verilog/mem_fifo.sv
verilog/rd_sequencer.sv
verilog/read_tracker.sv
verilog/dnn_rd_adapter.sv
tb/dnn_rd_adapter_props.sv
tb/tb_dnn_rd_adapter.sv

/* tb/tb_dnn_rd_adapter.sv */
/* Testbench for the read adapter: random-grant memory model with in-order delayed
   responses, a stimulus table of macro reads, and address and data checks. */
`timescale 1ns/100ps

module tb_dnn_rd_adapter;
	import dnn_mem_pkg::*;

	localparam int N_TESTS = 6;
	localparam int TIMEOUT_CYCLES = 5000;
	// response data is the word address scrambled with this key
	localparam data_t DATA_KEY = 64'h5a3c_96e1_0f87_d24b;

	// one row per test, n_req macro reads are sent back to back
	typedef struct packed {
		addr_t       addr;
		size_t       size;
		logic [3:0]  n_req;
		logic [7:0]  stall_pct;
		logic [7:0]  max_delay;
		logic [15:0] exp_words;
	} test_t;

	logic  clk = 1'b0;
	logic  rst;
	logic  rd_req;
	addr_t rd_addr;
	size_t rd_req_size;
	logic  rd_ready;
	logic  mem_req_valid;
	addr_t mem_req_addr;
	logic  mem_req_grant;
	logic  mem_resp_valid;
	data_t mem_resp_data;
	logic  mem_resp_grant;
	logic  inbuf_full;
	logic  inbuf_push;
	data_t data_to_inbuf;

	test_t tests [N_TESTS];
	addr_t exp_addrs [$];
	addr_t grant_addrs [$];
	data_t got_data [$];
	// memory model, granted addresses waiting for their response cycle
	addr_t resp_addr [$];
	int    resp_due [$];
	int    cycle = 0;
	int    grant_delay = 1;
	int    stall_pct = 0;
	int    max_delay = 1;
	int    errors = 0;
	int    tests_failed = 0;
	bit    timed_out = 1'b0;

	dnn_rd_adapter dnn_rd_adapter_inst (.*);

	always #50 clk = ~clk;

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
		errors++;
	endtask

	// memory and input buffer side, all randomness lives in this thread
	initial begin
		mem_req_grant = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data = '0;
		inbuf_full = 1'b0;
		void'($urandom(32'h82a5_6bc9));
		forever begin
			@(negedge clk);
			if (rst) begin
				mem_req_grant = 1'b0;
				mem_resp_valid = 1'b0;
				inbuf_full = 1'b0;
			end else begin
				mem_req_grant = ($urandom_range(3, 0) != 0);
				grant_delay = $urandom_range(max_delay, 1);
				inbuf_full = ($urandom_range(99, 0) < stall_pct);
				// oldest response is offered once its delay has run out
				if (resp_addr.size() > 0 && resp_due[0] <= cycle) begin
					mem_resp_valid = 1'b1;
					mem_resp_data = data_t'(resp_addr[0]) ^ DATA_KEY;
				end else begin
					mem_resp_valid = 1'b0;
				end
			end
		end
	end

	// observe handshakes on the rising edge, before any register updates
	always @(posedge clk) begin
		int due;
		cycle = cycle + 1;
		if (!rst) begin
			if (mem_req_valid && mem_req_grant) begin
				grant_addrs.push_back(mem_req_addr);
				// never earlier than the previous response, keeps order
				due = cycle + grant_delay;
				if (resp_due.size() > 0 && resp_due[$] > due) begin
					due = resp_due[$];
				end
				resp_addr.push_back(mem_req_addr);
				resp_due.push_back(due);
			end
			if (mem_resp_valid && mem_resp_grant) begin
				void'(resp_addr.pop_front());
				void'(resp_due.pop_front());
			end
			if (inbuf_push) begin
				got_data.push_back(data_to_inbuf);
			end
		end
	end

	initial begin
		int wait_cnt;
		int errs_before;
		int asrt_before;
		addr_t base;
		data_t exp_data;
		rst = 1'b1;
		rd_req = 1'b0;
		rd_addr = '0;
		rd_req_size = '0;
		// addr, size, back-to-back count, stall %, max response delay, words expected
		tests[0] = {32'h0000_1000, 10'd1, 4'd1, 8'd0, 8'd1, 16'd1};
		tests[1] = {32'h0000_2000, 10'd8, 4'd1, 8'd0, 8'd3, 16'd8};
		tests[2] = {32'h0001_0040, 10'd12, 4'd1, 8'd50, 8'd4, 16'd12};
		tests[3] = {32'h0002_0000, 10'd5, 4'd3, 8'd20, 8'd2, 16'd15};
		tests[4] = {32'h0003_0100, 10'd40, 4'd1, 8'd30, 8'd30, 16'd40};
		tests[5] = {32'h8000_0ff8, 10'd20, 4'd2, 8'd70, 8'd8, 16'd40};
		repeat (10) @(negedge clk);
		// memory thread still sees reset at this edge
		rst <= 1'b0;
		@(negedge clk);
		// idle state straight out of reset
		if (rd_ready !== 1'b1) report_mismatch("rd_ready", rd_ready, 1);
		if (mem_req_valid !== 1'b0) report_mismatch("mem_req_valid", mem_req_valid, 0);
		if (inbuf_push !== 1'b0) report_mismatch("inbuf_push", inbuf_push, 0);
		if (mem_resp_grant !== 1'b0) report_mismatch("mem_resp_grant", mem_resp_grant, 0);
		for (int t = 0; t < N_TESTS && !timed_out; t++) begin
			errs_before = errors;
			asrt_before = dnn_rd_adapter_inst.props_inst.fail_count;
			exp_addrs.delete();
			grant_addrs.delete();
			got_data.delete();
			// new memory model settings apply from the next edge on
			stall_pct <= int'(tests[t].stall_pct);
			max_delay <= int'(tests[t].max_delay);
			for (int r = 0; r < int'(tests[t].n_req); r++) begin
				base = tests[t].addr + addr_t'(r) * 32'h1000;
				for (int k = 0; k < int'(tests[t].size); k++) begin
					exp_addrs.push_back(base + addr_t'(k * WORD_BYTES));
				end
				rd_req = 1'b1;
				rd_addr = base;
				rd_req_size = tests[t].size;
				@(negedge clk);
			end
			rd_req = 1'b0;
			// queued work must pull rd_ready low
			if (rd_ready !== 1'b0) report_mismatch("rd_ready", rd_ready, 0);
			wait_cnt = 0;
			while (rd_ready !== 1'b1 && wait_cnt < TIMEOUT_CYCLES) begin
				@(negedge clk);
				wait_cnt++;
			end
			if (rd_ready !== 1'b1) begin
				$display("test %0d: rd_ready never came back high, read side stuck", t);
				errors++;
				timed_out = 1'b1;
			end else begin
				if (grant_addrs.size() != int'(tests[t].exp_words))
					report_mismatch("granted request count", grant_addrs.size(),
						tests[t].exp_words);
				if (got_data.size() != int'(tests[t].exp_words))
					report_mismatch("inbuf_push count", got_data.size(),
						tests[t].exp_words);
				for (int k = 0; k < exp_addrs.size(); k++) begin
					exp_data = data_t'(exp_addrs[k]) ^ DATA_KEY;
					if (k < grant_addrs.size() && grant_addrs[k] !== exp_addrs[k])
						report_mismatch($sformatf("mem_req_addr[%0d]", k), grant_addrs[k],
							exp_addrs[k]);
					if (k < got_data.size() && got_data[k] !== exp_data)
						report_mismatch($sformatf("data_to_inbuf[%0d]", k), got_data[k],
							exp_data);
				end
			end
			stall_pct <= 0;
			// port assertion failures during this test count as errors too
			errors += dnn_rd_adapter_inst.props_inst.fail_count - asrt_before;
			if (errors != errs_before) tests_failed++;
			$display("test %0d %s: %0d words in %0d cycles, %0d errors", t,
				(errors == errs_before) ? "ok" : "failed", exp_addrs.size(), wait_cnt,
				errors - errs_before);
		end
		$display("tests failed %0d of %0d, total errors %0d, assertion failures %0d",
			tests_failed, N_TESTS, errors, dnn_rd_adapter_inst.props_inst.fail_count);
		if (errors == 0 && dnn_rd_adapter_inst.props_inst.fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* tb/dnn_rd_adapter_props.sv */
/* Concurrent port checks for the read adapter, bound into every dnn_rd_adapter.
   Covers request hold until grant, input buffer back-pressure and response grant. */
`timescale 1ns/100ps

module dnn_rd_adapter_props
	import dnn_mem_pkg::*;
(
	input logic  clk,
	input logic  rst,
	input logic  mem_req_valid,
	input addr_t mem_req_addr,
	input logic  mem_req_grant,
	input logic  mem_resp_valid,
	input logic  mem_resp_grant,
	input logic  inbuf_full,
	input logic  inbuf_push
);

	// number of assertion failures so far
	int fail_count = 0;

	// a waiting request keeps both valid and address until granted
	req_addr_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid && !mem_req_grant |=> mem_req_valid && $stable(mem_req_addr))
		else begin
			$error("mem_req_addr changed while waiting for grant");
			fail_count++;
		end

	// input buffer back-pressure is always honored
	inbuf_no_overflow: assert property (@(posedge clk) disable iff (rst)
		inbuf_full |-> !inbuf_push)
		else begin
			$error("inbuf_push high while inbuf_full");
			fail_count++;
		end

	// response grant only answers a valid response
	resp_grant_needs_valid: assert property (@(posedge clk) disable iff (rst)
		mem_resp_grant |-> mem_resp_valid)
		else begin
			$error("mem_resp_grant high without mem_resp_valid");
			fail_count++;
		end

endmodule

bind dnn_rd_adapter dnn_rd_adapter_props props_inst (.*);

/* verilog/dnn_rd_adapter.sv */
/* Read side of the DNN accelerator memory adapter, top level.
   Connects the macro and request queues, the sequencer and the read tracker. */
`timescale 1ns/100ps

module dnn_rd_adapter
	import dnn_mem_pkg::*;
(
	input  logic  clk,
	input  logic  rst,

	// macro read requests from the accelerator
	input  logic  rd_req,
	input  addr_t rd_addr,
	input  size_t rd_req_size,
	output logic  rd_ready,

	// memory request port
	output logic  mem_req_valid,
	output addr_t mem_req_addr,
	input  logic  mem_req_grant,

	// memory response port
	input  logic  mem_resp_valid,
	input  data_t mem_resp_data,
	output logic  mem_resp_grant,

	// accelerator input buffer
	input  logic  inbuf_full,
	output logic  inbuf_push,
	output data_t data_to_inbuf
);

	logic issue;
	logic track_full;
	logic track_idle;

	// queued macro reads and queued micro read addresses
	fifo_if #(.T(macro_req_t)) macro_q ();
	fifo_if #(.T(addr_t))      req_q ();

	mem_fifo #(.T(macro_req_t)) macro_fifo (
		.clk (clk),
		.rst (rst),
		.q   (macro_q.store)
	);

	mem_fifo #(.T(addr_t)) req_fifo (
		.clk (clk),
		.rst (rst),
		.q   (req_q.store)
	);

	rd_sequencer sequencer (
		.clk           (clk),
		.rst           (rst),
		.rd_req        (rd_req),
		.rd_addr       (rd_addr),
		.rd_req_size   (rd_req_size),
		.rd_ready      (rd_ready),
		.macro_in      (macro_q.enq),
		.macro_out     (macro_q.deq),
		.req_in        (req_q.enq),
		.req_out       (req_q.deq),
		.mem_req_valid (mem_req_valid),
		.mem_req_addr  (mem_req_addr),
		.mem_req_grant (mem_req_grant),
		.issue         (issue),
		.track_full    (track_full),
		.track_idle    (track_idle)
	);

	read_tracker tracker (
		.clk            (clk),
		.rst            (rst),
		.issue          (issue),
		.track_full     (track_full),
		.track_idle     (track_idle),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_data  (mem_resp_data),
		.mem_resp_grant (mem_resp_grant),
		.inbuf_full     (inbuf_full),
		.inbuf_push     (inbuf_push),
		.data_to_inbuf  (data_to_inbuf)
	);

endmodule

/* verilog/read_tracker.sv */
/* Counts outstanding micro reads, buffers in-order memory responses and pushes
   them into the accelerator input buffer under its back-pressure. */
`timescale 1ns/100ps

module read_tracker
	import dnn_mem_pkg::*;
(
	input  logic  clk,
	input  logic  rst,

	// from the sequencer
	input  logic  issue,
	output logic  track_full,
	output logic  track_idle,

	// memory response port
	input  logic  mem_resp_valid,
	input  data_t mem_resp_data,
	output logic  mem_resp_grant,

	// accelerator input buffer
	input  logic  inbuf_full,
	output logic  inbuf_push,
	output data_t data_to_inbuf
);

	// reads issued and not yet delivered
	logic [OUT_CNT_W-1:0] outstanding;

	// response queue, this module is both producer and consumer
	fifo_if #(.T(data_t)) resp_q ();

	mem_fifo #(
		.T (data_t)
	) resp_fifo (
		.clk (clk),
		.rst (rst),
		.q   (resp_q.store)
	);

	assign track_full = (outstanding == OUT_CNT_W'(MAX_OUTSTANDING));
	assign track_idle = (outstanding == '0);

	// take a response whenever there is space for it
	assign resp_q.push      = mem_resp_valid && !resp_q.full;
	assign resp_q.push_data = mem_resp_data;
	assign mem_resp_grant   = resp_q.push;

	// responses come back in issue order, so the queue head is the oldest read
	assign inbuf_push    = !resp_q.empty && !track_idle && !inbuf_full;
	assign resp_q.pop    = inbuf_push;
	assign data_to_inbuf = resp_q.pop_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			outstanding <= '0;
		end else begin
			case ({issue, inbuf_push})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				// issue and delivery together cancel out
				default: outstanding <= outstanding;
			endcase
		end
	end

endmodule

/* verilog/rd_sequencer.sv */
/* Accepts macro reads, breaks each into one 8-byte micro read per word and
   presents the micro reads to the memory request port from the request queue. */
`timescale 1ns/100ps

module rd_sequencer
	import dnn_mem_pkg::*;
(
	input  logic  clk,
	input  logic  rst,

	// macro read intake
	input  logic  rd_req,
	input  addr_t rd_addr,
	input  size_t rd_req_size,
	output logic  rd_ready,

	// macro queue, both sides
	fifo_if.enq   macro_in,
	fifo_if.deq   macro_out,

	// micro read queue, both sides
	fifo_if.enq   req_in,
	fifo_if.deq   req_out,

	// memory request port
	output logic  mem_req_valid,
	output addr_t mem_req_addr,
	input  logic  mem_req_grant,

	// to and from the read tracker
	output logic  issue,
	input  logic  track_full,
	input  logic  track_idle
);

	// macro request currently being fractured
	logic  active;
	addr_t cur_addr;
	size_t words_left;

	logic load;
	logic last_word;

	// a request arriving while the queue is full is dropped
	assign macro_in.push      = rd_req && !macro_in.full;
	assign macro_in.push_data = '{addr: rd_addr, size: rd_req_size};

	// pick up the next macro read only when idle
	assign load          = !active && !macro_out.empty;
	assign macro_out.pop = load;

	// one micro read per cycle, needs room downstream and under the outstanding limit
	assign issue     = active && !req_in.full && !track_full;
	assign last_word = (words_left == size_t'(1));

	assign req_in.push      = issue;
	assign req_in.push_data = cur_addr;

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
		end else if (load) begin
			active <= 1'b1;
		end else if (issue && last_word) begin
			// done in the same cycle as the final word
			active <= 1'b0;
		end
	end

	// address and remaining count, only meaningful while active
	always_ff @(posedge clk) begin
		if (load) begin
			cur_addr   <= macro_out.pop_data.addr;
			words_left <= macro_out.pop_data.size;
		end else if (issue) begin
			cur_addr   <= cur_addr + addr_t'(WORD_BYTES);
			words_left <= words_left - size_t'(1);
		end
	end

	// head of the request queue held until granted
	assign mem_req_valid = !req_out.empty;
	assign mem_req_addr  = req_out.pop_data;
	assign req_out.pop   = mem_req_valid && mem_req_grant;

	// whole read side drained, nothing queued, issuing or outstanding
	assign rd_ready = macro_out.empty && req_out.empty && !active && track_idle;

endmodule

/* verilog/mem_fifo.sv */
/* Synchronous circular-buffer FIFO behind a fifo_if store port.
   Push while full and pop while empty are ignored. */
`timescale 1ns/100ps

module mem_fifo
	import dnn_mem_pkg::*;
#(
	parameter type T = logic,
	parameter int LOG_DEPTH = Q_LOG_DEPTH
) (
	input logic clk,
	input logic rst,
	fifo_if.store q
);

	// storage, no reset needed on payload
	T mem [1 << LOG_DEPTH];

	logic [LOG_DEPTH-1:0] wr_ptr;
	logic [LOG_DEPTH-1:0] rd_ptr;
	// occupancy, one bit wider than the pointers
	logic [LOG_DEPTH:0]   count;

	logic do_push;
	logic do_pop;

	// top count bit is set only when every entry is taken
	assign q.full  = count[LOG_DEPTH];
	assign q.empty = (count == '0);

	assign do_push = q.push && !q.full;
	assign do_pop  = q.pop && !q.empty;

	// head entry shown combinationally
	assign q.pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= q.push_data;
		end
	end

	// pointers wrap on their own at the power-of-two depth
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// push and pop together leave the count unchanged
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* verilog/fifo_if.sv */
/* Queue port bundle between a mem_fifo and its producer and consumer.
   The payload type is set per instance. */
`timescale 1ns/100ps

interface fifo_if #(
	parameter type T = logic
);

	// producer side
	logic push;
	T     push_data;
	logic full;

	// consumer side, head entry valid while empty is low
	logic pop;
	T     pop_data;
	logic empty;

	// writes into the queue
	modport enq (
		output push, push_data,
		input  full
	);

	// reads the head and pops it
	modport deq (
		output pop,
		input  pop_data, empty
	);

	// the storage itself
	modport store (
		input  push, push_data, pop,
		output full, pop_data, empty
	);

endinterface

/* verilog/dnn_mem_pkg.sv */
/* Shared widths, queue depths and request types for the DNN memory read adapter.
   Modules take what they need from here with a wildcard import in their header. */
package dnn_mem_pkg;

	// byte address and data word widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	// word count of one macro request
	localparam int SIZE_W = 10;

	// every micro read fetches one 64-bit word
	localparam int WORD_BYTES = 8;

	// default queue depth is 2**Q_LOG_DEPTH entries
	localparam int Q_LOG_DEPTH = 4;

	// reads issued but not yet handed to the input buffer
	localparam int MAX_OUTSTANDING = 16;
	localparam int OUT_CNT_W = $clog2(MAX_OUTSTANDING + 1);

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [SIZE_W-1:0] size_t;

	// one macro read as it sits in the intake queue
	typedef struct packed {
		addr_t addr;
		size_t size;
	} macro_req_t;

endpackage
